//--- filelist.f
mips_pkg.sv
ctrl_if.sv
main_control.sv
register_file.sv
operand_gen.sv
id_ex_reg.sv
decode_stage.sv
decode_props.sv
decode_stage_tb.sv

//--- decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;
	import mips_pkg::*;

	typedef struct
	{
		string       name;
		logic [31:0] instr;
		logic [31:0] pc_next;
		logic [1:0]  stall_flush;
		ex_ctrl_t    ex;
		mem_ctrl_t   mem;
		wb_ctrl_t    wb;
		logic [2:0]  flags;
	} test_vec_t;

	logic        clk = 1'b0;
	logic        rst_n = 1'b0;
	logic        stall = 1'b0;
	logic        flush = 1'b0;
	logic [31:0] pc_next = '0;
	logic [31:0] instr = '0;
	logic        reg_write = 1'b0;
	logic [31:0] write_data = '0;
	logic [4:0]  write_reg = '0;
	logic [31:0] pc_branch, pc_jump, reg1, reg2, sign_ext;
	logic [4:0]  rs, rt, rd, shamt;
	ex_ctrl_t    ex_ctrl;
	mem_ctrl_t   mem_ctrl;
	wb_ctrl_t    wb_ctrl;
	logic        jump, jump_register, illegal;

	test_vec_t   tests [$];
	string       test_name;
	logic [31:0] rng_state = 32'h1394_c6ba;
	logic [31:0] shadow [num_regs];
	int          cycle_count = 0;
	int          cycle_limit;

	// Expected contents of the ID/EX register
	ex_ctrl_t    exp_ex;
	mem_ctrl_t   exp_mem;
	wb_ctrl_t    exp_wb;
	logic [31:0] exp_pc_branch, exp_sign_ext;
	logic [4:0]  exp_rs, exp_rt, exp_rd, exp_shamt;

	decode_stage dut_i
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.stall         (stall),
		.flush         (flush),
		.pc_next       (pc_next),
		.instr         (instr),
		.reg_write     (reg_write),
		.write_data    (write_data),
		.write_reg     (write_reg),
		.pc_branch     (pc_branch),
		.pc_jump       (pc_jump),
		.reg1          (reg1),
		.reg2          (reg2),
		.sign_ext      (sign_ext),
		.rs            (rs),
		.rt            (rt),
		.rd            (rd),
		.shamt         (shamt),
		.ex_ctrl       (ex_ctrl),
		.mem_ctrl      (mem_ctrl),
		.wb_ctrl       (wb_ctrl),
		.jump          (jump),
		.jump_register (jump_register),
		.illegal       (illegal)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Regression failed");
			$fatal(1);
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic [31:0] rtype(input logic [4:0] s, input logic [4:0] t,
		input logic [4:0] d, input logic [4:0] sh, input logic [5:0] fn);
		return {6'h00, s, t, d, sh, fn};
	endfunction

	function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] s,
		input logic [4:0] t, input logic [15:0] imm);
		return {op, s, t, imm};
	endfunction

	function automatic logic [31:0] jtype(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	// {reg_dst, alu_src}, operation, {branch, branch_ne}
	function automatic ex_ctrl_t ex_fields(input logic [1:0] dst_src, input alu_op_e op,
		input logic [1:0] br);
		ex_ctrl_t e;
		e.reg_dst   = dst_src[1];
		e.alu_src   = dst_src[0];
		e.alu_op    = op;
		e.branch    = br[1];
		e.branch_ne = br[0];
		return e;
	endfunction

	// andi and ori zero extend, all others sign extend
	function automatic logic [31:0] extend_imm(input logic [31:0] ins);
		if (ins[31:26] == 6'h0c || ins[31:26] == 6'h0d)
			return {16'h0000, ins[15:0]};
		return {{16{ins[15]}}, ins[15:0]};
	endfunction

	task automatic check_value(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("** Error %s %s: expected 0x%08h, actual 0x%08h",
				test_name, field, expected, actual);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic check_registered();
		check_value("ex_ctrl", exp_ex, ex_ctrl);
		check_value("mem_ctrl", exp_mem, mem_ctrl);
		check_value("wb_ctrl", exp_wb, wb_ctrl);
		check_value("pc_branch", exp_pc_branch, pc_branch);
		check_value("sign_ext", exp_sign_ext, sign_ext);
		check_value("rs", exp_rs, rs);
		check_value("rt", exp_rt, rt);
		check_value("rd", exp_rd, rd);
		check_value("shamt", exp_shamt, shamt);
	endtask

	// flags is {jump, jump_register, illegal}
	// sf is {stall, flush}
	task automatic add_test(input string name, input logic [31:0] ins, input logic [31:0] pc,
		input logic [1:0] sf, input ex_ctrl_t ex, input logic [1:0] mem,
		input logic [2:0] wb, input logic [2:0] flags);
		test_vec_t t;
		t.name        = name;
		t.instr       = ins;
		t.pc_next     = pc;
		t.stall_flush = sf;
		t.ex          = ex;
		t.mem         = mem;
		t.wb          = wb;
		t.flags       = flags;
		tests.push_back(t);
	endtask

	////////////////////////////////////////
	// Decode table
	////////////////////////////////////////

	task automatic build_table();
		add_test("add", rtype(5'd1, 5'd2, 5'd3, 5'd0, 6'h20), 32'h0040_0004, 2'b00,
			ex_fields(2'b10, alu_add, 2'b00), 2'b00, 3'b100, 3'b000);
		add_test("sub", rtype(5'd4, 5'd5, 5'd6, 5'd0, 6'h22), 32'h0040_0008, 2'b00,
			ex_fields(2'b10, alu_sub, 2'b00), 2'b00, 3'b100, 3'b000);
		add_test("and", rtype(5'd7, 5'd8, 5'd9, 5'd0, 6'h24), 32'h0040_000c, 2'b00,
			ex_fields(2'b10, alu_and, 2'b00), 2'b00, 3'b100, 3'b000);
		add_test("or", rtype(5'd10, 5'd11, 5'd12, 5'd0, 6'h25), 32'h0040_0010, 2'b00,
			ex_fields(2'b10, alu_or, 2'b00), 2'b00, 3'b100, 3'b000);
		add_test("nor", rtype(5'd13, 5'd14, 5'd15, 5'd0, 6'h27), 32'h0040_0014, 2'b00,
			ex_fields(2'b10, alu_nor, 2'b00), 2'b00, 3'b100, 3'b000);
		add_test("slt", rtype(5'd16, 5'd17, 5'd18, 5'd0, 6'h2a), 32'h0040_0018, 2'b00,
			ex_fields(2'b10, alu_slt, 2'b00), 2'b00, 3'b100, 3'b000);
		add_test("sll", rtype(5'd0, 5'd19, 5'd20, 5'd5, 6'h00), 32'h0040_001c, 2'b00,
			ex_fields(2'b10, alu_sll, 2'b00), 2'b00, 3'b100, 3'b000);
		add_test("srl", rtype(5'd0, 5'd21, 5'd22, 5'd31, 6'h02), 32'h0040_0020, 2'b00,
			ex_fields(2'b10, alu_srl, 2'b00), 2'b00, 3'b100, 3'b000);
		add_test("jr", rtype(5'd31, 5'd0, 5'd0, 5'd0, 6'h08), 32'h0040_0024, 2'b00,
			ex_fields(2'b00, alu_add, 2'b00), 2'b00, 3'b000, 3'b010);
		add_test("lw", itype(6'h23, 5'd4, 5'd5, 16'hfffc), 32'h0040_0028, 2'b00,
			ex_fields(2'b01, alu_add, 2'b00), 2'b10, 3'b110, 3'b000);
		add_test("sw", itype(6'h2b, 5'd6, 5'd7, 16'h0010), 32'h0040_002c, 2'b00,
			ex_fields(2'b01, alu_add, 2'b00), 2'b01, 3'b000, 3'b000);
		add_test("beq", itype(6'h04, 5'd8, 5'd9, 16'h8000), 32'h0040_0030, 2'b00,
			ex_fields(2'b00, alu_sub, 2'b10), 2'b00, 3'b000, 3'b000);
		add_test("bne", itype(6'h05, 5'd10, 5'd11, 16'h7fff), 32'h0040_0034, 2'b00,
			ex_fields(2'b00, alu_sub, 2'b01), 2'b00, 3'b000, 3'b000);
		add_test("addi", itype(6'h08, 5'd12, 5'd13, 16'h8001), 32'h0040_0038, 2'b00,
			ex_fields(2'b01, alu_add, 2'b00), 2'b00, 3'b100, 3'b000);
		add_test("andi", itype(6'h0c, 5'd14, 5'd15, 16'hf0f0), 32'h0040_003c, 2'b00,
			ex_fields(2'b01, alu_and, 2'b00), 2'b00, 3'b100, 3'b000);
		add_test("ori", itype(6'h0d, 5'd16, 5'd17, 16'h8421), 32'h0040_0040, 2'b00,
			ex_fields(2'b01, alu_or, 2'b00), 2'b00, 3'b100, 3'b000);
		add_test("slti", itype(6'h0a, 5'd18, 5'd19, 16'hffff), 32'h0040_0044, 2'b00,
			ex_fields(2'b01, alu_slt, 2'b00), 2'b00, 3'b100, 3'b000);
		add_test("lui", itype(6'h0f, 5'd0, 5'd20, 16'h1234), 32'h0040_0048, 2'b00,
			ex_fields(2'b01, alu_lui, 2'b00), 2'b00, 3'b100, 3'b000);
		add_test("j", jtype(6'h02, 26'h3ff_ffff), 32'ha000_0000, 2'b00,
			ex_fields(2'b00, alu_add, 2'b00), 2'b00, 3'b000, 3'b100);
		add_test("jal", jtype(6'h03, 26'h012_3456), 32'h5000_1000, 2'b00,
			ex_fields(2'b00, alu_add, 2'b00), 2'b00, 3'b101, 3'b100);
		// Two stalled cycles, stall over flush while jal is held, then flush
		add_test("stall_1", rtype(5'd21, 5'd22, 5'd23, 5'd7, 6'h20), 32'h0040_0050, 2'b10,
			ex_fields(2'b10, alu_add, 2'b00), 2'b00, 3'b100, 3'b000);
		add_test("stall_2", itype(6'h23, 5'd24, 5'd25, 16'h8000), 32'h0040_0054, 2'b10,
			ex_fields(2'b01, alu_add, 2'b00), 2'b10, 3'b110, 3'b000);
		add_test("stall_flush", itype(6'h2b, 5'd28, 5'd29, 16'h0020), 32'h0040_005c, 2'b11,
			ex_fields(2'b01, alu_add, 2'b00), 2'b01, 3'b000, 3'b000);
		add_test("flush", itype(6'h23, 5'd26, 5'd27, 16'h0004), 32'h0040_0058, 2'b01,
			ex_fields(2'b01, alu_add, 2'b00), 2'b10, 3'b110, 3'b000);
		add_test("bad_opcode", itype(6'h3f, 5'd1, 5'd2, 16'h1111), 32'h0040_0060, 2'b00,
			ex_fields(2'b00, alu_add, 2'b00), 2'b00, 3'b000, 3'b001);
		add_test("bad_funct", rtype(5'd1, 5'd2, 5'd3, 5'd0, 6'h3f), 32'h0040_0064, 2'b00,
			ex_fields(2'b00, alu_add, 2'b00), 2'b00, 3'b000, 3'b001);
		add_test("recover", rtype(5'd3, 5'd4, 5'd5, 5'd0, 6'h20), 32'h0040_0068, 2'b00,
			ex_fields(2'b10, alu_add, 2'b00), 2'b00, 3'b100, 3'b000);
	endtask

	task automatic apply_test(input test_vec_t t);
		test_name = t.name;
		instr     = t.instr;
		pc_next   = t.pc_next;
		stall     = t.stall_flush[1];
		flush     = t.stall_flush[0];
		#2;
		check_value("jump", t.flags[2], jump);
		check_value("jump_register", t.flags[1], jump_register);
		check_value("illegal", t.flags[0], illegal);
		check_value("pc_jump", {t.pc_next[31:28], t.instr[25:0], 2'b00}, pc_jump);
		check_value("reg1", shadow[t.instr[25:21]], reg1);
		check_value("reg2", shadow[t.instr[20:16]], reg2);
		// Stall holds everything, flush clears only control
		if (!stall)
		begin
			exp_pc_branch = t.pc_next;
			exp_sign_ext  = extend_imm(t.instr);
			exp_rs        = t.instr[25:21];
			exp_rt        = t.instr[20:16];
			exp_rd        = t.instr[15:11];
			exp_shamt     = t.instr[10:6];
			exp_ex        = flush ? '0 : t.ex;
			exp_mem       = flush ? '0 : t.mem;
			exp_wb        = flush ? '0 : t.wb;
		end
		@(posedge clk);
		#1;
		check_registered();
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		logic [31:0] value;
		build_table();
		cycle_limit = 2 * tests.size() + 2 * num_regs + 20;
		for (int r = 0; r < num_regs; r++)
			shadow[r] = '0;
		{exp_ex, exp_mem, exp_wb} = '0;
		{exp_pc_branch, exp_sign_ext, exp_rs, exp_rt, exp_rd, exp_shamt} = '0;

		repeat (2) @(posedge clk);
		#1;
		test_name = "reset";
		check_registered();
		rst_n = 1'b1;

		// Write every register, reading it back the same cycle
		test_name = "regfile_write";
		for (int r = 0; r < num_regs; r++)
		begin
			value      = next_random();
			reg_write  = 1'b1;
			write_reg  = 5'(r);
			write_data = value;
			instr      = rtype(5'(r), 5'(r), 5'd0, 5'd0, 6'h20);
			#2;
			check_value("reg1 bypass", (r == 0) ? 32'h0 : value, reg1);
			check_value("reg2 bypass", (r == 0) ? 32'h0 : value, reg2);
			if (r != 0)
				shadow[r] = value;
			@(posedge clk);
			#1;
		end
		reg_write = 1'b0;

		test_name = "regfile_read";
		for (int r = 0; r < num_regs; r++)
		begin
			instr = rtype(5'(r), 5'(num_regs - 1 - r), 5'd0, 5'd0, 6'h20);
			#2;
			check_value("reg1", shadow[r], reg1);
			check_value("reg2", shadow[num_regs - 1 - r], reg2);
			@(posedge clk);
			#1;
		end

		foreach (tests[i])
			apply_test(tests[i]);

		// One more edge so the bound properties see the last entry
		@(posedge clk);
		#1;
		if (dut_i.u_id_ex_reg.props_i.violation_count == 0)
		begin
			$display("Regression passed");
			$finish;
		end
		else
		begin
			$display("ID/EX register properties were violated %0d times",
				dut_i.u_id_ex_reg.props_i.violation_count);
			$display("Regression failed");
			$fatal(1);
		end
	end

endmodule

//--- decode_props.sv
`timescale 1ns/1ps

module decode_props
(
	input logic                            clk,
	input logic                            rst_n,
	input logic                            stall,
	input logic                            flush,
	input logic [mips_pkg::data_w-1:0]     pc_branch,
	input logic [mips_pkg::data_w-1:0]     sign_ext,
	input logic [mips_pkg::reg_addr_w-1:0] rs,
	input logic [mips_pkg::reg_addr_w-1:0] rt,
	input logic [mips_pkg::reg_addr_w-1:0] rd,
	input logic [mips_pkg::reg_addr_w-1:0] shamt,
	input mips_pkg::ex_ctrl_t              ex_ctrl,
	input mips_pkg::mem_ctrl_t             mem_ctrl,
	input mips_pkg::wb_ctrl_t              wb_ctrl
);

	int violation_count = 0;

	// Sync reset leaves a bubble behind
	reset_bubble: assert property (@(posedge clk)
		!rst_n |=> (ex_ctrl == '0 && mem_ctrl == '0 && wb_ctrl == '0))
	else
	begin
		violation_count++;
		$error("Control fields not cleared one cycle after reset");
	end

	stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> ($stable(ex_ctrl) && $stable(mem_ctrl) && $stable(wb_ctrl)
			&& $stable(pc_branch) && $stable(sign_ext) && $stable(rs)
			&& $stable(rt) && $stable(rd) && $stable(shamt)))
	else
	begin
		violation_count++;
		$error("Registered outputs changed during stall");
	end

	flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		(flush && !stall) |=> (ex_ctrl == '0 && mem_ctrl == '0 && wb_ctrl == '0))
	else
	begin
		violation_count++;
		$error("Control fields not cleared after flush");
	end

	// Load and store never at once
	mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_ctrl.mem_read && mem_ctrl.mem_write))
	else
	begin
		violation_count++;
		$error("mem_read and mem_write both high");
	end

endmodule

bind id_ex_reg decode_props props_i
(
	.clk       (clk),
	.rst_n     (rst_n),
	.stall     (stall),
	.flush     (flush),
	.pc_branch (pc_branch),
	.sign_ext  (sign_ext),
	.rs        (rs),
	.rt        (rt),
	.rd        (rd),
	.shamt     (shamt),
	.ex_ctrl   (ex_ctrl),
	.mem_ctrl  (mem_ctrl),
	.wb_ctrl   (wb_ctrl)
);

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage
(
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            stall,
	input  logic                            flush,
	input  logic [mips_pkg::data_w-1:0]     pc_next,
	input  logic [mips_pkg::data_w-1:0]     instr,
	input  logic                            reg_write,
	input  logic [mips_pkg::data_w-1:0]     write_data,
	input  logic [mips_pkg::reg_addr_w-1:0] write_reg,
	output logic [mips_pkg::data_w-1:0]     pc_branch,
	output logic [mips_pkg::data_w-1:0]     pc_jump,
	output logic [mips_pkg::data_w-1:0]     reg1,
	output logic [mips_pkg::data_w-1:0]     reg2,
	output logic [mips_pkg::data_w-1:0]     sign_ext,
	output logic [mips_pkg::reg_addr_w-1:0] rs,
	output logic [mips_pkg::reg_addr_w-1:0] rt,
	output logic [mips_pkg::reg_addr_w-1:0] rd,
	output logic [mips_pkg::reg_addr_w-1:0] shamt,
	output mips_pkg::ex_ctrl_t              ex_ctrl,
	output mips_pkg::mem_ctrl_t             mem_ctrl,
	output mips_pkg::wb_ctrl_t              wb_ctrl,
	output logic                            jump,
	output logic                            jump_register,
	output logic                            illegal
);
	import mips_pkg::*;

	ctrl_if   ctrl_bus ();
	fields_if field_bus ();

	main_control u_main_control
	(
		.ctrl   (ctrl_bus.ctrl_src),
		.opcode (opcode_e'(instr[31:26])),
		.funct  (funct_e'(instr[5:0]))
	);

	// Reads are combinational, same cycle as instr
	register_file u_register_file
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.read_addr_1 (instr[25:21]),
		.read_addr_2 (instr[20:16]),
		.read_data_1 (reg1),
		.read_data_2 (reg2),
		.write_en    (reg_write),
		.write_addr  (write_reg),
		.write_data  (write_data)
	);

	operand_gen u_operand_gen
	(
		.instr   (instr),
		.pc_next (pc_next),
		.imm     (ctrl_bus.imm_dst),
		.fields  (field_bus.fld_src)
	);

	id_ex_reg u_id_ex_reg
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.stall     (stall),
		.flush     (flush),
		.pc_next   (pc_next),
		.ctrl      (ctrl_bus.ctrl_dst),
		.fields    (field_bus.fld_dst),
		.pc_branch (pc_branch),
		.sign_ext  (sign_ext),
		.rs        (rs),
		.rt        (rt),
		.rd        (rd),
		.shamt     (shamt),
		.ex_ctrl   (ex_ctrl),
		.mem_ctrl  (mem_ctrl),
		.wb_ctrl   (wb_ctrl)
	);

	// Undelayed decode straight to fetch
	assign pc_jump       = field_bus.pc_jump;
	assign jump          = ctrl_bus.jump;
	assign jump_register = ctrl_bus.jump_register;
	assign illegal       = ctrl_bus.illegal;

endmodule

//--- id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg
(
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            stall,
	input  logic                            flush,
	input  logic [mips_pkg::data_w-1:0]     pc_next,
	ctrl_if.ctrl_dst                        ctrl,
	fields_if.fld_dst                       fields,
	output logic [mips_pkg::data_w-1:0]     pc_branch,
	output logic [mips_pkg::data_w-1:0]     sign_ext,
	output logic [mips_pkg::reg_addr_w-1:0] rs,
	output logic [mips_pkg::reg_addr_w-1:0] rt,
	output logic [mips_pkg::reg_addr_w-1:0] rd,
	output logic [mips_pkg::reg_addr_w-1:0] shamt,
	output mips_pkg::ex_ctrl_t              ex_ctrl,
	output mips_pkg::mem_ctrl_t             mem_ctrl,
	output mips_pkg::wb_ctrl_t              wb_ctrl
);
	import mips_pkg::*;

	////////////////////////////////////////
	// Data fields
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pc_branch <= '0;
			sign_ext  <= '0;
			rs        <= '0;
			rt        <= '0;
			rd        <= '0;
			shamt     <= '0;
		end
		else if (!stall)
		begin
			// Flush does not touch the data path
			pc_branch <= pc_next;
			sign_ext  <= fields.sign_ext;
			rs        <= fields.rs;
			rt        <= fields.rt;
			rd        <= fields.rd;
			shamt     <= fields.shamt;
		end
	end

	////////////////////////////////////////
	// Control fields
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n || (flush && !stall))
		begin
			// Bubble
			ex_ctrl  <= '0;
			mem_ctrl <= '0;
			wb_ctrl  <= '0;
		end
		else if (!stall)
		begin
			ex_ctrl  <= ctrl.ex;
			mem_ctrl <= ctrl.mem;
			wb_ctrl  <= ctrl.wb;
		end
	end

endmodule

//--- operand_gen.sv
`timescale 1ns/1ps

module operand_gen
(
	input  logic [mips_pkg::data_w-1:0] instr,
	input  logic [mips_pkg::data_w-1:0] pc_next,
	ctrl_if.imm_dst                     imm,
	fields_if.fld_src                   fields
);
	import mips_pkg::*;

	localparam int imm_w = 16;

	logic [imm_w-1:0] imm_field;

	////////////////////////////////////////
	// Register and shift fields
	////////////////////////////////////////

	assign fields.rs    = instr[25:21];
	assign fields.rt    = instr[20:16];
	assign fields.rd    = instr[15:11];
	assign fields.shamt = instr[10:6];

	////////////////////////////////////////
	// Immediate
	////////////////////////////////////////

	assign imm_field = instr[imm_w-1:0];

	// andi and ori take zeros, everything else the sign bit
	always_comb
	begin
		if (imm.imm_zero)
			fields.sign_ext = {{(data_w-imm_w){1'b0}}, imm_field};
		else
			fields.sign_ext = {{(data_w-imm_w){imm_field[imm_w-1]}}, imm_field};
	end

	// Jump target stays in the current 256 MB region
	assign fields.pc_jump = {pc_next[data_w-1 -: 4], instr[25:0], 2'b00};

endmodule

//--- register_file.sv
`timescale 1ns/1ps

module register_file
(
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [mips_pkg::reg_addr_w-1:0] read_addr_1,
	input  logic [mips_pkg::reg_addr_w-1:0] read_addr_2,
	output logic [mips_pkg::data_w-1:0]     read_data_1,
	output logic [mips_pkg::data_w-1:0]     read_data_2,
	input  logic                            write_en,
	input  logic [mips_pkg::reg_addr_w-1:0] write_addr,
	input  logic [mips_pkg::data_w-1:0]     write_data
);
	import mips_pkg::*;

	logic [data_w-1:0] regs [num_regs];

	// One read port, with r0 forced low and the pending write bypassed
	function automatic logic [data_w-1:0] read_port(input logic [reg_addr_w-1:0] addr);
		logic [data_w-1:0] data;
		if (addr == '0)
			data = '0;
		else if (write_en && (write_addr == addr))
			data = write_data;
		else
			data = regs[addr];
		return data;
	endfunction

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
		end
		else if (write_en && (write_addr != '0))
		begin
			regs[write_addr] <= write_data;
		end
	end

	always_comb
	begin
		read_data_1 = read_port(read_addr_1);
		read_data_2 = read_port(read_addr_2);
	end

endmodule

//--- main_control.sv
`timescale 1ns/1ps

module main_control
(
	ctrl_if.ctrl_src       ctrl,
	input mips_pkg::opcode_e opcode,
	input mips_pkg::funct_e  funct
);
	import mips_pkg::*;

	always_comb
	begin
		// Bubble unless the decode below says otherwise
		ctrl.ex            = '0;
		ctrl.mem           = '0;
		ctrl.wb            = '0;
		ctrl.jump          = 1'b0;
		ctrl.jump_register = 1'b0;
		ctrl.imm_zero      = 1'b0;
		ctrl.illegal       = 1'b0;

		case (opcode)
			op_r_type:
			begin
				ctrl.ex.reg_dst   = 1'b1;
				ctrl.wb.reg_write = 1'b1;
				case (funct)
					fn_add: ctrl.ex.alu_op = alu_add;
					fn_sub: ctrl.ex.alu_op = alu_sub;
					fn_and: ctrl.ex.alu_op = alu_and;
					fn_or:  ctrl.ex.alu_op = alu_or;
					fn_nor: ctrl.ex.alu_op = alu_nor;
					fn_slt: ctrl.ex.alu_op = alu_slt;
					fn_sll: ctrl.ex.alu_op = alu_sll;
					fn_srl: ctrl.ex.alu_op = alu_srl;
					fn_jr:
					begin
						// Register jump, nothing written back
						ctrl.ex.reg_dst    = 1'b0;
						ctrl.wb.reg_write  = 1'b0;
						ctrl.jump_register = 1'b1;
					end
					default:
					begin
						ctrl.ex.reg_dst   = 1'b0;
						ctrl.wb.reg_write = 1'b0;
						ctrl.illegal      = 1'b1;
					end
				endcase
			end

			////////////////////////////////////////
			// Memory access
			////////////////////////////////////////

			op_lw:
			begin
				ctrl.ex.alu_src    = 1'b1;
				ctrl.ex.alu_op     = alu_add;
				ctrl.mem.mem_read  = 1'b1;
				ctrl.wb.reg_write  = 1'b1;
				ctrl.wb.mem_to_reg = 1'b1;
			end
			op_sw:
			begin
				ctrl.ex.alu_src    = 1'b1;
				ctrl.ex.alu_op     = alu_add;
				ctrl.mem.mem_write = 1'b1;
			end

			////////////////////////////////////////
			// Branches and jumps
			////////////////////////////////////////

			op_beq:
			begin
				ctrl.ex.alu_op = alu_sub;
				ctrl.ex.branch = 1'b1;
			end
			op_bne:
			begin
				ctrl.ex.alu_op    = alu_sub;
				ctrl.ex.branch_ne = 1'b1;
			end
			op_j:
				ctrl.jump = 1'b1;
			op_jal:
			begin
				// Return address goes to r31
				ctrl.jump         = 1'b1;
				ctrl.wb.reg_write = 1'b1;
				ctrl.wb.link      = 1'b1;
			end

			////////////////////////////////////////
			// Immediate arithmetic and logic
			////////////////////////////////////////

			op_addi:
			begin
				ctrl.ex.alu_src   = 1'b1;
				ctrl.ex.alu_op    = alu_add;
				ctrl.wb.reg_write = 1'b1;
			end
			op_andi, op_ori:
			begin
				// Logical immediates are zero extended
				ctrl.ex.alu_src   = 1'b1;
				ctrl.ex.alu_op    = (opcode == op_andi) ? alu_and : alu_or;
				ctrl.wb.reg_write = 1'b1;
				ctrl.imm_zero     = 1'b1;
			end
			op_slti:
			begin
				ctrl.ex.alu_src   = 1'b1;
				ctrl.ex.alu_op    = alu_slt;
				ctrl.wb.reg_write = 1'b1;
			end
			op_lui:
			begin
				ctrl.ex.alu_src   = 1'b1;
				ctrl.ex.alu_op    = alu_lui;
				ctrl.wb.reg_write = 1'b1;
			end

			default:
				ctrl.illegal = 1'b1;
		endcase
	end

endmodule

//--- ctrl_if.sv
`timescale 1ns/1ps

// Decoded control from main_control
interface ctrl_if;
	import mips_pkg::*;

	ex_ctrl_t  ex;
	mem_ctrl_t mem;
	wb_ctrl_t  wb;
	logic      jump;
	logic      jump_register;
	logic      imm_zero;
	logic      illegal;

	modport ctrl_src (output ex, mem, wb, jump, jump_register, imm_zero, illegal);
	modport ctrl_dst (input ex, mem, wb);
	modport imm_dst (input imm_zero);
endinterface

// Instruction fields and derived operands
interface fields_if;
	import mips_pkg::*;

	logic [data_w-1:0]     sign_ext;
	logic [reg_addr_w-1:0] rs;
	logic [reg_addr_w-1:0] rt;
	logic [reg_addr_w-1:0] rd;
	logic [reg_addr_w-1:0] shamt;
	logic [data_w-1:0]     pc_jump;

	modport fld_src (output sign_ext, rs, rt, rd, shamt, pc_jump);
	modport fld_dst (input sign_ext, rs, rt, rd, shamt);
endinterface

//--- mips_pkg.sv
package mips_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	localparam int data_w     = 32;
	localparam int reg_addr_w = 5;
	localparam int num_regs   = 32;

	////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////

	// Major opcodes, instr[31:26]
	typedef enum logic [5:0]
	{
		op_r_type = 6'h00,
		op_j      = 6'h02,
		op_jal    = 6'h03,
		op_beq    = 6'h04,
		op_bne    = 6'h05,
		op_addi   = 6'h08,
		op_slti   = 6'h0a,
		op_andi   = 6'h0c,
		op_ori    = 6'h0d,
		op_lui    = 6'h0f,
		op_lw     = 6'h23,
		op_sw     = 6'h2b
	} opcode_e;

	// R-type function codes, instr[5:0]
	typedef enum logic [5:0]
	{
		fn_sll = 6'h00,
		fn_srl = 6'h02,
		fn_jr  = 6'h08,
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_nor = 6'h27,
		fn_slt = 6'h2a
	} funct_e;

	// Operations handed to execute
	typedef enum logic [3:0]
	{
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_or  = 4'd3,
		alu_nor = 4'd4,
		alu_slt = 4'd5,
		alu_sll = 4'd6,
		alu_srl = 4'd7,
		alu_lui = 4'd8
	} alu_op_e;

	////////////////////////////////////////
	// Per-stage control bundles
	////////////////////////////////////////

	typedef struct packed
	{
		logic    reg_dst;
		logic    alu_src;
		alu_op_e alu_op;
		logic    branch;
		logic    branch_ne;
	} ex_ctrl_t;

	typedef struct packed
	{
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	typedef struct packed
	{
		logic reg_write;
		logic mem_to_reg;
		logic link;
	} wb_ctrl_t;

endpackage
